/* Makefile */
SRCS := $(shell cat fir_decim.f)

all: run

obj_dir/Vtb_fir_decim: fir_decim.f $(SRCS)
	verilator --binary --assert --top-module tb_fir_decim -f fir_decim.f

run: obj_dir/Vtb_fir_decim fir_decim_testdata.txt
	@out="$$(./obj_dir/Vtb_fir_decim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir

.PHONY: all run clean

/* bank_combiner.sv */
`timescale 1ns/1ps

module bank_combiner #(
   parameter int DECIM     = 4,
   parameter int OUT_SHIFT = 12
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  bank_done,
   input  fir_types_pkg::acc_t   bank_acc [DECIM],
   output fir_bus_pkg::fir_out_t result
);

   import fir_types_pkg::*;

   localparam acc_t SAT_HI = acc_t'({1'b0, {(DOUT_W-1){1'b1}}});
   localparam acc_t SAT_LO = -SAT_HI - acc_t'(1);

   acc_t  sum;
   acc_t  shifted;
   dout_t sat_val;
   logic  valid_q;
   dout_t data_q;

   // full width sum over all phases
   always_comb begin
      sum = '0;
      for (int p = 0; p < DECIM; p++) begin
         sum = sum + bank_acc[p];
      end
   end

   assign shifted = sum >>> OUT_SHIFT;

   // clamp to the output range
   always_comb begin
      if (shifted > SAT_HI) begin
         sat_val = dout_t'(SAT_HI);
      end else if (shifted < SAT_LO) begin
         sat_val = dout_t'(SAT_LO);
      end else begin
         sat_val = dout_t'(shifted);
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= bank_done;
      end
   end

   always_ff @(posedge clk) begin
      if (bank_done) begin
         data_q <= sat_val;
      end
   end

   assign result = '{valid: valid_q, data: data_q};

endmodule

/* fir_bus_pkg.sv */
package fir_bus_pkg;

   import fir_types_pkg::*;

   // one tap write at flat tap index addr
   typedef struct packed {
      coef_addr_t addr;
      coef_t      data;
   } coef_wr_t;

   // one decimated output sample
   typedef struct packed {
      logic  valid;
      dout_t data;
   } fir_out_t;

   // bank multiply-accumulate sequencer
   typedef enum logic {
      MAC_IDLE,
      MAC_RUN
   } mac_state_t;

endpackage

/* fir_decim.f */
fir_types_pkg.sv
fir_bus_pkg.sv
sample_commutator.sv
poly_bank.sv
bank_combiner.sv
fir_decim_top.sv
tb_fir_decim.sv

/* fir_decim_testdata.txt */
# tap <index> <value> | in <sample> | out <expected> <name> | rst
# an out record follows the in record that completes its frame
tap 0 32000
tap 1 28000
tap 2 -24000
tap 3 20000
tap 4 -8000
tap 5 4000
tap 6 2000
tap 7 -1200
tap 8 800
tap 9 -400
tap 10 200
tap 11 100
in 0
in 0
in 0
in 1024
out 8000 impulse_h0
in 0
in 0
in 0
in 0
out -2000 impulse_h4
in 0
in 0
in 0
in 0
out 200 impulse_h8
in 256
in -512
in 1024
in -256
out 9250 mixed_f3
in 512
in 768
in -1024
in 300
out -5482 mixed_f4
in -2048
in 0
in 0
in 0
out -11530 mixed_f5
in 1000
in -1000
rst
in 100
in 200
in -300
in 400
out 390 after_reset
in 2047
in -2048
in 2047
in 2047
out 32767 sat_max
in -2048
in 2047
in -2048
in -2048
out -32768 sat_min
in 2047
in 2047
in 2047

/* fir_decim_top.sv */
`timescale 1ns/1ps

module fir_decim_top #(
   parameter int DECIM     = 4,
   parameter int BANK_LEN  = 3,
   parameter int OUT_SHIFT = 12
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   in_valid,
   input  fir_types_pkg::sample_t in_sample,
   input  logic                   coef_we,
   input  fir_bus_pkg::coef_wr_t  coef_wr,
   output fir_bus_pkg::fir_out_t  result
);

   import fir_types_pkg::*;

   logic    frame_valid;
   sample_t frame [DECIM];
   acc_t    bank_acc [DECIM];
   logic    lead_done;

   sample_commutator #(
      .DECIM (DECIM)
   ) u_commutator (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid    (in_valid),
      .in_sample   (in_sample),
      .frame_valid (frame_valid),
      .frame       (frame)
   );

   // bank 0 flags completion for all lockstep banks
   for (genvar p = 0; p < DECIM; p++) begin : g_bank
      if (p == 0) begin : g_lead
         poly_bank #(
            .DECIM    (DECIM),
            .BANK_LEN (BANK_LEN),
            .PHASE    (p)
         ) u_bank (
            .clk          (clk),
            .rst_n        (rst_n),
            .coef_we      (coef_we),
            .coef_wr      (coef_wr),
            .frame_valid  (frame_valid),
            .phase_sample (frame[p]),
            .bank_done    (lead_done),
            .bank_acc     (bank_acc[p])
         );
      end else begin : g_rest
         poly_bank #(
            .DECIM    (DECIM),
            .BANK_LEN (BANK_LEN),
            .PHASE    (p)
         ) u_bank (
            .clk          (clk),
            .rst_n        (rst_n),
            .coef_we      (coef_we),
            .coef_wr      (coef_wr),
            .frame_valid  (frame_valid),
            .phase_sample (frame[p]),
            .bank_done    (),
            .bank_acc     (bank_acc[p])
         );
      end
   end

   bank_combiner #(
      .DECIM     (DECIM),
      .OUT_SHIFT (OUT_SHIFT)
   ) u_combiner (
      .clk       (clk),
      .rst_n     (rst_n),
      .bank_done (lead_done),
      .bank_acc  (bank_acc),
      .result    (result)
   );

endmodule

/* fir_types_pkg.sv */
package fir_types_pkg;

   // input samples from the converter
   localparam int SAMPLE_W = 12;

   // filter taps
   localparam int COEF_W = 16;

   // holds every product sum without overflow
   localparam int ACC_W = 32;

   // scaled result
   localparam int DOUT_W = 16;

   // flat tap address on the write port
   localparam int COEF_ADDR_W = 8;

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic signed [COEF_W-1:0]   coef_t;
   typedef logic signed [ACC_W-1:0]    acc_t;
   typedef logic signed [DOUT_W-1:0]   dout_t;
   typedef logic [COEF_ADDR_W-1:0]     coef_addr_t;

endpackage

/* poly_bank.sv */
`timescale 1ns/1ps

module poly_bank #(
   parameter int DECIM    = 4,
   parameter int BANK_LEN = 3,
   parameter int PHASE    = 0
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   coef_we,
   input  fir_bus_pkg::coef_wr_t  coef_wr,
   input  logic                   frame_valid,
   input  fir_types_pkg::sample_t phase_sample,
   output logic                   bank_done,
   output fir_types_pkg::acc_t    bank_acc
);

   import fir_types_pkg::*;
   import fir_bus_pkg::*;

   localparam int IDX_W = (BANK_LEN > 1) ? $clog2(BANK_LEN) : 1;

   // taps h[PHASE + j*DECIM], j = 0 .. BANK_LEN-1
   coef_t      coef_mem [BANK_LEN];
   sample_t    hist [BANK_LEN];

   mac_state_t state;
   logic [IDX_W-1:0] tap_idx;
   logic       last_tap;
   logic       accumulate;
   acc_t       acc_q;
   acc_t       product;
   acc_t       mac_sum;

   coef_addr_t wr_slot;
   logic       wr_hit;

   // tap write port
   assign wr_slot = coef_addr_t'(int'(coef_wr.addr) / DECIM);
   assign wr_hit  = coef_we
                    && ((int'(coef_wr.addr) % DECIM) == PHASE)
                    && (int'(wr_slot) < BANK_LEN);

   always_ff @(posedge clk) begin
      if (wr_hit) begin
         coef_mem[wr_slot[IDX_W-1:0]] <= coef_wr.data;
      end
   end

   // one phase sample per frame, newest at hist[0]
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int j = 0; j < BANK_LEN; j++) begin
            hist[j] <= '0;
         end
      end else if (frame_valid) begin
         hist[0] <= phase_sample;
         for (int j = 1; j < BANK_LEN; j++) begin
            hist[j] <= hist[j-1];
         end
      end
   end

   assign last_tap = (tap_idx == IDX_W'(BANK_LEN - 1));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= MAC_IDLE;
         tap_idx <= '0;
      end else begin
         case (state)
            MAC_IDLE: begin
               if (frame_valid) begin
                  state   <= MAC_RUN;
                  tap_idx <= '0;
               end
            end
            MAC_RUN: begin
               if (last_tap) begin
                  state <= MAC_IDLE;
               end else begin
                  tap_idx <= tap_idx + 1'b1;
               end
            end
            default: state <= MAC_IDLE;
         endcase
      end
   end

   // first tap loads, later taps add on
   assign accumulate = (tap_idx != '0);
   assign product    = acc_t'(coef_mem[tap_idx]) * acc_t'(hist[tap_idx]);
   assign mac_sum    = (accumulate ? acc_q : '0) + product;

   always_ff @(posedge clk) begin
      if (state == MAC_RUN) begin
         acc_q <= mac_sum;
      end
   end

   // final sum is ready during the last tap cycle
   assign bank_done = (state == MAC_RUN) && last_tap;
   assign bank_acc  = mac_sum;

endmodule

/* sample_commutator.sv */
`timescale 1ns/1ps

module sample_commutator #(
   parameter int DECIM = 4
) (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   in_valid,
   input  fir_types_pkg::sample_t in_sample,
   output logic                   frame_valid,
   output fir_types_pkg::sample_t frame [DECIM]
);

   localparam int CNT_W = (DECIM > 1) ? $clog2(DECIM) : 1;

   logic [CNT_W-1:0] phase_cnt;
   logic             frame_last;

   // this sample completes a frame
   assign frame_last = in_valid && (phase_cnt == CNT_W'(DECIM - 1));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         phase_cnt <= '0;
      end else if (in_valid) begin
         if (frame_last) begin
            phase_cnt <= '0;
         end else begin
            phase_cnt <= phase_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         frame_valid <= 1'b0;
      end else begin
         frame_valid <= frame_last;
      end
   end

   // element 0 newest, element DECIM-1 oldest
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < DECIM; i++) begin
            frame[i] <= '0;
         end
      end else if (in_valid) begin
         frame[0] <= in_sample;
         for (int i = 1; i < DECIM; i++) begin
            frame[i] <= frame[i-1];
         end
      end
   end

   // frame stays stable for the frame_valid cycle;
   // the next sample only shifts in at the edge that ends it

endmodule

/* tb_fir_decim.sv */
`timescale 1ns/1ps

module tb_fir_decim;

   import fir_types_pkg::*;
   import fir_bus_pkg::*;

   localparam int DECIM     = 4;
   localparam int BANK_LEN  = 3;
   localparam int OUT_SHIFT = 12;
   localparam int LATENCY   = BANK_LEN + 2;

   logic     clk = 1'b0;
   logic     rst_n;
   logic     in_valid;
   sample_t  in_sample;
   logic     coef_we;
   coef_wr_t coef_wr;
   fir_out_t result;

   int          cycle = 0;
   int          errors;
   int          checked;
   int          in_count;
   int unsigned lcg_state;

   // expected outputs in file order
   int    exp_val_q[$];
   string exp_name_q[$];
   // cycle of each frame-completing sample
   int    frame_end_q[$];
   string lines[$];

   fir_decim_top #(
      .DECIM     (DECIM),
      .BANK_LEN  (BANK_LEN),
      .OUT_SHIFT (OUT_SHIFT)
   ) dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (in_valid),
      .in_sample (in_sample),
      .coef_we   (coef_we),
      .coef_wr   (coef_wr),
      .result    (result)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   // 0 to 2 idle cycles before a sample
   function automatic int next_gap();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return int'((lcg_state >> 16) % 3);
   endfunction

   task automatic write_tap(input int addr, input int value);
      @(negedge clk);
      in_valid     = 1'b0;
      coef_we      = 1'b1;
      coef_wr.addr = coef_addr_t'(addr);
      coef_wr.data = coef_t'(value);
   endtask

   task automatic send_sample(input int value);
      int gap;

      gap = next_gap();
      repeat (gap) begin
         @(negedge clk);
         in_valid = 1'b0;
         coef_we  = 1'b0;
      end
      @(negedge clk);
      coef_we   = 1'b0;
      in_valid  = 1'b1;
      in_sample = sample_t'(value);
      in_count++;
      if (in_count % DECIM == 0) begin
         frame_end_q.push_back(cycle);
      end
   endtask

   // let every completed frame come out
   task automatic wait_drain();
      int waited;

      @(negedge clk);
      in_valid = 1'b0;
      coef_we  = 1'b0;
      waited   = 0;
      while (frame_end_q.size() > 0 && waited < 4 * LATENCY) begin
         @(negedge clk);
         waited++;
      end
      assert (frame_end_q.size() == 0) else begin
         errors++;
         $display("%0d completed frame(s) gave no output", frame_end_q.size());
      end
      frame_end_q.delete();
   endtask

   task automatic apply_reset(input int n);
      @(negedge clk);
      in_valid = 1'b0;
      coef_we  = 1'b0;
      rst_n    = 1'b0;
      repeat (n) @(negedge clk);
      rst_n    = 1'b1;
      in_count = 0;
   endtask

   task automatic check_result();
      int    exp_cycle;
      int    exp_val;
      string name;

      assert (frame_end_q.size() > 0) else begin
         errors++;
         $display("extra output %0d at cycle %0d without a completed frame",
                  result.data, cycle);
      end
      assert (exp_val_q.size() > 0) else begin
         errors++;
         $display("output %0d at cycle %0d has no expected value left",
                  result.data, cycle);
      end
      if (frame_end_q.size() > 0 && exp_val_q.size() > 0) begin
         exp_cycle = frame_end_q.pop_front();
         exp_val   = exp_val_q.pop_front();
         name      = exp_name_q.pop_front();
         checked++;
         assert (cycle - exp_cycle == LATENCY) else begin
            errors++;
            $display("%s: output came %0d cycles after its frame, not %0d",
                     name, cycle - exp_cycle, LATENCY);
         end
         assert (result.data == dout_t'(exp_val)) else begin
            errors++;
            $display("error %s: expected %0d, actual %0d", name, exp_val, result.data);
         end
      end
   endtask

   task automatic watch_outputs();
      forever begin
         @(negedge clk);
         if (result.valid) begin
            check_result();
         end
      end
   endtask

   task automatic watchdog(input int limit);
      wait (cycle >= limit);
      $display("timeout: run still going after %0d cycles", limit);
      $display("outputs checked: %0d, errors: %0d", checked, errors + 1);
      $display("Simulation FAILED");
      $finish;
   endtask

   initial begin
      int    fd;
      int    rc;
      int    a;
      int    b;
      int    n_in;
      string line;
      string kw;
      string name;

      rst_n     = 1'b0;
      in_valid  = 1'b0;
      in_sample = '0;
      coef_we   = 1'b0;
      coef_wr   = '0;
      errors    = 0;
      checked   = 0;
      in_count  = 0;
      lcg_state = 10;
      n_in      = 0;

      fd = $fopen("fir_decim_testdata.txt", "r");
      assert (fd != 0) else begin
         errors++;
         $display("cannot open fir_decim_testdata.txt");
      end
      if (fd != 0) begin
         while (!$feof(fd)) begin
            line = "";
            rc   = $fgets(line, fd);
            if (rc > 0) begin
               lines.push_back(line);
            end
         end
         $fclose(fd);
      end
      foreach (lines[i]) begin
         kw = "";
         rc = $sscanf(lines[i], "%s", kw);
         if (kw == "in") begin
            n_in++;
         end
      end

      fork
         watch_outputs();
         watchdog(n_in * 4 + 200);
      join_none

      apply_reset(8);
      foreach (lines[i]) begin
         kw = "";
         rc = $sscanf(lines[i], "%s", kw);
         if (kw == "tap") begin
            rc = $sscanf(lines[i], "%s %d %d", kw, a, b);
            write_tap(a, b);
         end else if (kw == "in") begin
            rc = $sscanf(lines[i], "%s %d", kw, a);
            send_sample(a);
         end else if (kw == "out") begin
            rc = $sscanf(lines[i], "%s %d %s", kw, a, name);
            exp_val_q.push_back(a);
            exp_name_q.push_back(name);
         end else if (kw == "rst") begin
            wait_drain();
            apply_reset(3);
         end
      end
      wait_drain();
      // trailing partial frame must stay silent
      repeat (2 * LATENCY) @(negedge clk);

      assert (exp_val_q.size() == 0) else begin
         errors++;
         $display("%0d expected output(s) never appeared", exp_val_q.size());
      end
      $display("outputs checked: %0d, errors: %0d", checked, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule
